// File: Bender.yml
package:
  name: shuffle

sources:
  - files:
      - shuffle_pkg.sv
      - shuffle_permute.sv
      - shuffle_tracker.sv
      - shuffle_pipe.sv
      - cluster_handshake.sv
      - shuffle_top.sv
  - target: test
    files:
      - shuffle_asserts.sv
      - tb_shuffle_top.sv

// File: cluster_handshake.sv
// Valid/ready glue between the shared pipes and the per-cluster read and write channels
`timescale 1ns/1ps

module cluster_handshake (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Read fork
  input  logic                               r_valid_i,
  output logic                               r_ready_o,
  output logic [shuffle_pkg::NrClusters-1:0] cl_r_valid_o,
  input  logic [shuffle_pkg::NrClusters-1:0] cl_r_ready_i,
  // Write join
  input  logic [shuffle_pkg::NrClusters-1:0] cl_w_valid_i,
  output logic [shuffle_pkg::NrClusters-1:0] cl_w_ready_o,
  output logic                               w_valid_o,
  input  logic                               w_ready_i
);

  //////////////////////////////////////////////////////////////////////
  // Read fork
  //////////////////////////////////////////////////////////////////////

  // Clusters that already took the current beat
  logic [shuffle_pkg::NrClusters-1:0] taken_q;
  logic [shuffle_pkg::NrClusters-1:0] r_accept;

  assign cl_r_valid_o = {shuffle_pkg::NrClusters{r_valid_i}} & ~taken_q;
  assign r_accept     = cl_r_valid_o & cl_r_ready_i;

  // Beat is done once every cluster has it, earlier or now
  assign r_ready_o = &(taken_q | r_accept);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= '0;
    end else if (r_ready_o) begin
      taken_q <= '0;
    end else begin
      taken_q <= taken_q | r_accept;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write join
  //////////////////////////////////////////////////////////////////////

  // All slices must be present, then all of them are taken together
  assign w_valid_o    = &cl_w_valid_i;
  assign cl_w_ready_o = {shuffle_pkg::NrClusters{w_valid_o & w_ready_i}};

endmodule

// File: list.f
shuffle_pkg.sv
shuffle_permute.sv
shuffle_tracker.sv
shuffle_pipe.sv
cluster_handshake.sv
shuffle_top.sv
shuffle_asserts.sv
tb_shuffle_top.sv

// File: shuffle_asserts.sv
// Handshake properties of shuffle_top, attached to every instance through bind
`timescale 1ns/1ps

module shuffle_asserts (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic                                   ar_valid_i,
  input logic                                   ar_ready_o,
  input logic                                   mem_ar_ready_i,
  input logic                                   rd_out_valid,
  input logic                                   rd_out_ready,
  input logic [shuffle_pkg::NrClusters-1:0]     cl_r_valid_o,
  input logic [shuffle_pkg::NrClusters-1:0]     cl_r_ready_i,
  input shuffle_pkg::beat_u                     cl_r_data_o,
  input logic                                   cl_r_last_o,
  input logic                                   mem_w_valid_o,
  input logic                                   mem_w_ready_i,
  input shuffle_pkg::beat_u                     mem_w_data_o,
  input logic [shuffle_pkg::TotalStrbWidth-1:0] mem_w_strb_o,
  input logic                                   mem_w_last_o
);

  int unsigned fail_cnt = 0;

  // Read requests accepted and not yet closed by a last beat to the clusters
  int unsigned rd_outstanding;

  //////////////////////////////////////////////////////////////////////
  // Request tracker
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_outstanding <= 0;
    end else begin
      rd_outstanding <= rd_outstanding + (ar_valid_i && ar_ready_o)
                        - (rd_out_valid && rd_out_ready && cl_r_last_o);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_outstanding == shuffle_pkg::NumTrackers |-> !ar_ready_o)
    else begin
      $error("ar_ready_o high with eight read requests outstanding");
      fail_cnt++;
    end

  // Ready follows memory again once a request has finished
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_outstanding < shuffle_pkg::NumTrackers |-> ar_ready_o == mem_ar_ready_i)
    else begin
      $error("ar_ready_o held low with a free read tracker entry");
      fail_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // Data handshakes
  //////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < shuffle_pkg::NrClusters; c++) begin : g_cluster
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      cl_r_valid_o[c] && !cl_r_ready_i[c] |=> cl_r_valid_o[c] && $stable(cl_r_data_o))
      else begin
        $error("Pending read beat changed before acceptance");
        fail_cnt++;
      end

    // Beat still owed to other clusters
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      cl_r_valid_o[c] && cl_r_ready_i[c] && !rd_out_ready |=> !cl_r_valid_o[c])
      else begin
        $error("Cluster read valid stays high after acceptance");
        fail_cnt++;
      end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_w_valid_o && !mem_w_ready_i |=> mem_w_valid_o && $stable(mem_w_data_o)
      && $stable(mem_w_strb_o) && $stable(mem_w_last_o))
    else begin
      $error("Pending memory write beat changed before acceptance");
      fail_cnt++;
    end

endmodule

bind shuffle_top shuffle_asserts u_shuffle_asserts (.*);

// File: shuffle_permute.sv
// One butterfly permutation stage, reused for read/write data (8-bit units) and strobes (1-bit)
`timescale 1ns/1ps

module shuffle_permute #(
  parameter int unsigned Stage    = 0,
  parameter bit          IsRead   = 1'b1,
  parameter int unsigned UnitBits = 8
) (
  input  logic [shuffle_pkg::TotalStrbWidth*UnitBits-1:0] in_i,
  input  logic                                            enable_i,
  output logic [shuffle_pkg::TotalStrbWidth*UnitBits-1:0] out_o
);

  // Block size doubles with every stage
  localparam int unsigned BlockSize  = (UnitBits * shuffle_pkg::NrLanes) << Stage;
  localparam int unsigned Iterations = shuffle_pkg::TotalStrbWidth * UnitBits / (2 * BlockSize);

  logic [shuffle_pkg::TotalStrbWidth*UnitBits-1:0] permuted;

  for (genvar i = 0; i < Iterations; i++) begin : g_iter
    for (genvar j = 0; j < 2; j++) begin : g_half
      if (IsRead) begin : g_rd
        // Interleave the lower and upper half of the beat
        assign permuted[(i*2+j)*BlockSize +: BlockSize] =
            in_i[(j*Iterations+i)*BlockSize +: BlockSize];
      end else begin : g_wr
        // Inverse, gather even blocks low and odd blocks high
        assign permuted[(j*Iterations+i)*BlockSize +: BlockSize] =
            in_i[(i*2+j)*BlockSize +: BlockSize];
      end
    end
  end

  // Disabled stages leave the beat untouched
  assign out_o = enable_i ? permuted : in_i;

endmodule

// File: shuffle_pipe.sv
// Permutation pipeline for one direction, stages separated by full-rate stream registers
`timescale 1ns/1ps

module shuffle_pipe #(
  parameter bit IsRead = 1'b1
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  shuffle_pkg::beat_u                   in_data_i,
  input  logic [shuffle_pkg::TotalStrbWidth-1:0] in_strb_i,
  input  logic                                 in_last_i,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output shuffle_pkg::beat_u                   out_data_o,
  output logic [shuffle_pkg::TotalStrbWidth-1:0] out_strb_o,
  output logic                                 out_last_o,
  input  logic [shuffle_pkg::NumStages-1:0]    stage_en_i,
  output logic [shuffle_pkg::NumStages-1:0]    stage_done_o
);

  // Per stage: handshake at the stage output, beat before and after permutation
  logic [shuffle_pkg::NumStages-1:0]                                   stg_valid;
  logic [shuffle_pkg::NumStages-1:0]                                   stg_ready;
  logic [shuffle_pkg::NumStages-1:0]                                   stg_last;
  logic [shuffle_pkg::NumStages-1:0][shuffle_pkg::TotalDataWidth-1:0]  stg_data_in;
  logic [shuffle_pkg::NumStages-1:0][shuffle_pkg::TotalDataWidth-1:0]  stg_data_out;
  logic [shuffle_pkg::NumStages-1:0][shuffle_pkg::TotalStrbWidth-1:0]  stg_strb_in;
  logic [shuffle_pkg::NumStages-1:0][shuffle_pkg::TotalStrbWidth-1:0]  stg_strb_out;

  // First stage sits directly on the input
  assign stg_valid[0]   = in_valid_i;
  assign in_ready_o     = stg_ready[0];
  assign stg_data_in[0] = in_data_i.flat;
  assign stg_strb_in[0] = in_strb_i;
  assign stg_last[0]    = in_last_i;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  for (genvar s = 0; s < shuffle_pkg::NumStages; s++) begin : g_stage
    shuffle_permute #(
      .Stage    (s),
      .IsRead   (IsRead),
      .UnitBits (8)
    ) u_data (
      .in_i     (stg_data_in[s]),
      .enable_i (stage_en_i[s]),
      .out_o    (stg_data_out[s])
    );

    shuffle_permute #(
      .Stage    (s),
      .IsRead   (IsRead),
      .UnitBits (1)
    ) u_strb (
      .in_i     (stg_strb_in[s]),
      .enable_i (stage_en_i[s]),
      .out_o    (stg_strb_out[s])
    );

    // Request boundary seen at this stage
    assign stage_done_o[s] = stg_valid[s] & stg_ready[s] & stg_last[s];
  end

  // Stream register in front of every stage but the first
  for (genvar s = 1; s < shuffle_pkg::NumStages; s++) begin : g_reg
    logic                                valid_q;
    logic                                last_q;
    logic [shuffle_pkg::TotalDataWidth-1:0] data_q;
    logic [shuffle_pkg::TotalStrbWidth-1:0] strb_q;

    // Takes a new beat whenever it is empty or drains in the same cycle
    assign stg_ready[s-1] = ~valid_q | stg_ready[s];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= 1'b0;
      end else if (stg_ready[s-1]) begin
        valid_q <= stg_valid[s-1];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stg_valid[s-1] && stg_ready[s-1]) begin
        data_q <= stg_data_out[s-1];
        strb_q <= stg_strb_out[s-1];
        last_q <= stg_last[s-1];
      end
    end

    assign stg_valid[s]   = valid_q;
    assign stg_last[s]    = last_q;
    assign stg_data_in[s] = data_q;
    assign stg_strb_in[s] = strb_q;
  end

  // Output taken from the final stage
  assign out_valid_o                     = stg_valid[shuffle_pkg::NumStages-1];
  assign stg_ready[shuffle_pkg::NumStages-1] = out_ready_i;
  assign out_data_o.flat                 = stg_data_out[shuffle_pkg::NumStages-1];
  assign out_strb_o                      = stg_strb_out[shuffle_pkg::NumStages-1];
  assign out_last_o                      = stg_last[shuffle_pkg::NumStages-1];

endmodule

// File: shuffle_pkg.sv
// Shared configuration and beat type for the cluster shuffler, referenced by scoped names
package shuffle_pkg;

  //////////////////////////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////////////////////////

  // Lanes inside one cluster
  localparam int unsigned NrLanes = 2;

  // Vector clusters fed by the shuffler
  localparam int unsigned NrClusters = 4;

  // Data slice of one cluster in bits
  localparam int unsigned ClusterDataWidth = 64;

  // Full memory beat
  localparam int unsigned TotalDataWidth = NrClusters * ClusterDataWidth;

  // One strobe bit per byte of the beat
  localparam int unsigned TotalStrbWidth = TotalDataWidth / 8;

  // Butterfly stages needed to spread 8-bit elements over the lanes
  localparam int unsigned NumStages = $clog2(ClusterDataWidth / (8 * NrLanes));

  // Requests in flight per direction
  localparam int unsigned NumTrackers = 8;

  // Element width code
  //   0 = 8-bit, 1 = 16-bit, 2 = 32-bit, 3 = 64-bit
  localparam int unsigned VewWidth = 2;

  //////////////////////////////////////////////////////////////////////
  // Beat layout
  //////////////////////////////////////////////////////////////////////

  // The permutation works on the flat word, the clusters see their own slice.
  // Cluster 0 sits in the lowest bits.
  typedef union packed {
    logic [TotalDataWidth-1:0]                   flat;
    logic [NrClusters-1:0][ClusterDataWidth-1:0] cluster;
  } beat_u;

endpackage

// File: shuffle_top.sv
// Top of the cluster shuffler, between the wide memory port and the vector clusters
`timescale 1ns/1ps

module shuffle_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Read requests
  input  logic                                   ar_valid_i,
  output logic                                   ar_ready_o,
  input  logic [shuffle_pkg::VewWidth-1:0]       ar_vew_i,
  output logic                                   mem_ar_valid_o,
  input  logic                                   mem_ar_ready_i,
  // Write requests
  input  logic                                   aw_valid_i,
  output logic                                   aw_ready_o,
  input  logic [shuffle_pkg::VewWidth-1:0]       aw_vew_i,
  output logic                                   mem_aw_valid_o,
  input  logic                                   mem_aw_ready_i,
  // Read data from memory
  input  logic                                   mem_r_valid_i,
  output logic                                   mem_r_ready_o,
  input  shuffle_pkg::beat_u                     mem_r_data_i,
  input  logic                                   mem_r_last_i,
  // Read data to the clusters
  output logic [shuffle_pkg::NrClusters-1:0]     cl_r_valid_o,
  input  logic [shuffle_pkg::NrClusters-1:0]     cl_r_ready_i,
  output shuffle_pkg::beat_u                     cl_r_data_o,
  output logic                                   cl_r_last_o,
  // Write data from the clusters
  input  logic [shuffle_pkg::NrClusters-1:0]     cl_w_valid_i,
  output logic [shuffle_pkg::NrClusters-1:0]     cl_w_ready_o,
  input  shuffle_pkg::beat_u                     cl_w_data_i,
  input  logic [shuffle_pkg::TotalStrbWidth-1:0] cl_w_strb_i,
  input  logic                                   cl_w_last_i,
  // Write data to memory
  output logic                                   mem_w_valid_o,
  input  logic                                   mem_w_ready_i,
  output shuffle_pkg::beat_u                     mem_w_data_o,
  output logic [shuffle_pkg::TotalStrbWidth-1:0] mem_w_strb_o,
  output logic                                   mem_w_last_o
);

  logic                              rd_full;
  logic                              wr_full;
  logic [shuffle_pkg::NumStages-1:0] rd_stage_en;
  logic [shuffle_pkg::NumStages-1:0] rd_stage_done;
  logic [shuffle_pkg::NumStages-1:0] wr_stage_en;
  logic [shuffle_pkg::NumStages-1:0] wr_stage_done;
  logic                              rd_out_valid;
  logic                              rd_out_ready;
  logic                              wr_in_valid;
  logic                              wr_in_ready;

  //////////////////////////////////////////////////////////////////////
  // Request handshakes
  //////////////////////////////////////////////////////////////////////

  // Requests go straight to memory, acceptance waits for a free tracker entry
  assign ar_ready_o     = mem_ar_ready_i & ~rd_full;
  assign mem_ar_valid_o = ar_valid_i;
  assign aw_ready_o     = mem_aw_ready_i & ~wr_full;
  assign mem_aw_valid_o = aw_valid_i;

  shuffle_tracker u_rd_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acc_i        (ar_valid_i & ar_ready_o),
    .acc_vew_i    (ar_vew_i),
    .stage_done_i (rd_stage_done),
    .stage_en_o   (rd_stage_en),
    .full_o       (rd_full)
  );

  shuffle_tracker u_wr_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acc_i        (aw_valid_i & aw_ready_o),
    .acc_vew_i    (aw_vew_i),
    .stage_done_i (wr_stage_done),
    .stage_en_o   (wr_stage_en),
    .full_o       (wr_full)
  );

  //////////////////////////////////////////////////////////////////////
  // Data paths
  //////////////////////////////////////////////////////////////////////

  // Read beats carry no strobe
  shuffle_pipe #(
    .IsRead (1'b1)
  ) u_rd_pipe (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (mem_r_valid_i),
    .in_ready_o   (mem_r_ready_o),
    .in_data_i    (mem_r_data_i),
    .in_strb_i    ('0),
    .in_last_i    (mem_r_last_i),
    .out_valid_o  (rd_out_valid),
    .out_ready_i  (rd_out_ready),
    .out_data_o   (cl_r_data_o),
    .out_strb_o   (),
    .out_last_o   (cl_r_last_o),
    .stage_en_i   (rd_stage_en),
    .stage_done_o (rd_stage_done)
  );

  shuffle_pipe #(
    .IsRead (1'b0)
  ) u_wr_pipe (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (wr_in_valid),
    .in_ready_o   (wr_in_ready),
    .in_data_i    (cl_w_data_i),
    .in_strb_i    (cl_w_strb_i),
    .in_last_i    (cl_w_last_i),
    .out_valid_o  (mem_w_valid_o),
    .out_ready_i  (mem_w_ready_i),
    .out_data_o   (mem_w_data_o),
    .out_strb_o   (mem_w_strb_o),
    .out_last_o   (mem_w_last_o),
    .stage_en_i   (wr_stage_en),
    .stage_done_o (wr_stage_done)
  );

  cluster_handshake u_cluster_handshake (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .r_valid_i    (rd_out_valid),
    .r_ready_o    (rd_out_ready),
    .cl_r_valid_o (cl_r_valid_o),
    .cl_r_ready_i (cl_r_ready_i),
    .cl_w_valid_i (cl_w_valid_i),
    .cl_w_ready_o (cl_w_ready_o),
    .w_valid_o    (wr_in_valid),
    .w_ready_i    (wr_in_ready)
  );

endmodule

// File: shuffle_tracker.sv
// Request ring for one direction, hands each permutation stage the enables of its current request
`timescale 1ns/1ps

module shuffle_tracker (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 acc_i,
  input  logic [shuffle_pkg::VewWidth-1:0]     acc_vew_i,
  input  logic [shuffle_pkg::NumStages-1:0]    stage_done_i,
  output logic [shuffle_pkg::NumStages-1:0]    stage_en_o,
  output logic                                 full_o
);

  localparam int unsigned PtrWidth = $clog2(shuffle_pkg::NumTrackers);

  logic [shuffle_pkg::NumTrackers-1:0][shuffle_pkg::NumStages-1:0] mask_q;
  logic [PtrWidth-1:0]                                              acc_ptr_q;
  logic [shuffle_pkg::NumStages-1:0][PtrWidth-1:0]                  issue_ptr_q;
  logic [PtrWidth:0]                                                cnt_q;
  logic [shuffle_pkg::NumStages-1:0]                                acc_mask;

  // A stage is active when its index reaches the width code
  always_comb begin
    for (int s = 0; s < shuffle_pkg::NumStages; s++) begin
      acc_mask[s] = (s >= acc_vew_i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Accept side
  //////////////////////////////////////////////////////////////////////

  // Pointers wrap on their own, the ring depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q    <= '0;
      acc_ptr_q <= '0;
    end else if (acc_i) begin
      mask_q[acc_ptr_q] <= acc_mask;
      acc_ptr_q         <= acc_ptr_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Issue side
  //////////////////////////////////////////////////////////////////////

  // Each stage moves on once the last beat of its request has left it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q <= '0;
    end else begin
      for (int s = 0; s < shuffle_pkg::NumStages; s++) begin
        if (stage_done_i[s]) begin
          issue_ptr_q[s] <= issue_ptr_q[s] + 1'b1;
        end
      end
    end
  end

  for (genvar s = 0; s < shuffle_pkg::NumStages; s++) begin : g_en
    assign stage_en_o[s] = mask_q[issue_ptr_q[s]][s];
  end

  // Entry is free again when the final stage is done with it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + {{PtrWidth{1'b0}}, acc_i}
                     - {{PtrWidth{1'b0}}, stage_done_i[shuffle_pkg::NumStages-1]};
    end
  end

  assign full_o = (cnt_q == shuffle_pkg::NumTrackers);

endmodule

// File: tb_shuffle_top.sv
// Random read and write traffic through shuffle_top, checked against a block shuffle model
`timescale 1ns/1ps

module tb_shuffle_top;

  localparam int unsigned NumReqs = 200;
  // 400 requests of up to 4 beats, 10 cycles each
  localparam int unsigned WatchdogCycles = 2 * NumReqs * 4 * 10;

  logic                                   clk_i;
  logic                                   rst_ni;
  logic                                   ar_valid_i, ar_ready_o, mem_ar_valid_o, mem_ar_ready_i;
  logic                                   aw_valid_i, aw_ready_o, mem_aw_valid_o, mem_aw_ready_i;
  logic [shuffle_pkg::VewWidth-1:0]       ar_vew_i;
  logic [shuffle_pkg::VewWidth-1:0]       aw_vew_i;
  logic                                   mem_r_valid_i, mem_r_ready_o, mem_r_last_i;
  shuffle_pkg::beat_u                     mem_r_data_i;
  logic [shuffle_pkg::NrClusters-1:0]     cl_r_valid_o, cl_r_ready_i;
  shuffle_pkg::beat_u                     cl_r_data_o;
  logic                                   cl_r_last_o;
  logic [shuffle_pkg::NrClusters-1:0]     cl_w_valid_i, cl_w_ready_o;
  shuffle_pkg::beat_u                     cl_w_data_i;
  logic [shuffle_pkg::TotalStrbWidth-1:0] cl_w_strb_i;
  logic                                   cl_w_last_i;
  logic                                   mem_w_valid_o, mem_w_ready_i, mem_w_last_o;
  shuffle_pkg::beat_u                     mem_w_data_o;
  logic [shuffle_pkg::TotalStrbWidth-1:0] mem_w_strb_o;

  int          seed = 72317;
  bit          directed;
  bit          rd_hold;
  int unsigned rd_sent, rd_checked, wr_sent, wr_checked;
  logic [shuffle_pkg::NrClusters-1:0] rd_taken;
  // Accepted requests, packed as length * 4 + width code
  int          rd_req_q[$];
  int          wr_req_q[$];
  logic [shuffle_pkg::TotalDataWidth-1:0] rd_exp_q[$];
  logic [shuffle_pkg::TotalDataWidth-1:0] wr_exp_q[$];
  logic [shuffle_pkg::TotalStrbWidth-1:0] wr_strb_q[$];
  bit          rd_last_q[$];
  bit          wr_last_q[$];

  shuffle_top DUT (.*);

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  function automatic logic [shuffle_pkg::TotalDataWidth-1:0] random_beat();
    logic [shuffle_pkg::TotalDataWidth-1:0] b;
    for (int k = 0; k < shuffle_pkg::TotalDataWidth / 32; k++) begin
      b[32*k +: 32] = $random(seed);
    end
    return b;
  endfunction

  // Byte-wise model, each enabled stage moves whole blocks, data byte and strobe bit together
  function automatic void shuffle_model(
    input  logic [shuffle_pkg::TotalDataWidth-1:0] din,
    input  logic [shuffle_pkg::TotalStrbWidth-1:0] sin,
    input  int                                     vew,
    input  bit                                     is_read,
    output logic [shuffle_pkg::TotalDataWidth-1:0] dout,
    output logic [shuffle_pkg::TotalStrbWidth-1:0] sout
  );
    logic [shuffle_pkg::TotalDataWidth-1:0] d;
    logic [shuffle_pkg::TotalStrbWidth-1:0] st;
    int bs;
    int iters;
    int blk;
    int src;
    d    = din;
    st   = sin;
    dout = din;
    sout = sin;
    for (int s = 0; s < shuffle_pkg::NumStages; s++) begin
      if (s >= vew) begin
        bs    = shuffle_pkg::NrLanes << s;
        iters = shuffle_pkg::TotalStrbWidth / (2 * bs);
        for (int k = 0; k < shuffle_pkg::TotalStrbWidth; k++) begin
          blk = k / bs;
          src = is_read ? (blk % 2) * iters + blk / 2 : (blk % iters) * 2 + blk / iters;
          src = src * bs + k % bs;
          dout[8*k +: 8] = d[8*src +: 8];
          sout[k]        = st[src];
        end
        d  = dout;
        st = sout;
      end
    end
  endfunction

  task automatic request_stream(input bit is_read, input int count);
    int vew;
    int len;
    bit accepted;
    for (int n = 0; n < count; n++) begin
      vew = $unsigned($random(seed)) % 4;
      len = $unsigned($random(seed)) % 4 + 1;
      if (is_read) begin
        ar_vew_i   = vew[1:0];
        ar_valid_i = 1'b1;
      end else begin
        aw_vew_i   = vew[1:0];
        aw_valid_i = 1'b1;
      end
      do begin
        @(negedge clk_i);
        accepted = is_read ? ar_ready_o : aw_ready_o;
      end while (!accepted);
      if (is_read) rd_req_q.push_back(len * 4 + vew);
      else wr_req_q.push_back(len * 4 + vew);
      @(posedge clk_i);
      #2;
      ar_valid_i = is_read ? 1'b0 : ar_valid_i;
      aw_valid_i = is_read ? aw_valid_i : 1'b0;
      repeat ($unsigned($random(seed)) % 3) begin
        @(posedge clk_i);
        #2;
      end
    end
  endtask

  // Memory side, beats of a request only once its AR has been taken
  task automatic read_data_stream(input int count);
    int req;
    logic [shuffle_pkg::TotalDataWidth-1:0] d;
    logic [shuffle_pkg::TotalDataWidth-1:0] want;
    logic [shuffle_pkg::TotalStrbWidth-1:0] no_strb;
    for (int n = 0; n < count; n++) begin
      while (rd_req_q.size() == 0 || rd_hold) begin
        @(posedge clk_i);
        #2;
      end
      req = rd_req_q.pop_front();
      for (int b = 0; b < req / 4; b++) begin
        d                 = random_beat();
        mem_r_data_i.flat = d;
        mem_r_last_i      = (b == req / 4 - 1);
        mem_r_valid_i     = 1'b1;
        do @(negedge clk_i); while (!mem_r_ready_o);
        shuffle_model(d, '0, req % 4, 1'b1, want, no_strb);
        rd_exp_q.push_back(want);
        rd_last_q.push_back(mem_r_last_i);
        rd_sent++;
        @(posedge clk_i);
        #2;
        mem_r_valid_i = 1'b0;
        repeat ($unsigned($random(seed)) % 3) begin
          @(posedge clk_i);
          #2;
        end
      end
    end
  endtask

  // Clusters raise their valids one by one until the join takes the beat
  task automatic write_data_stream(input int count);
    int req;
    int r;
    bit taken;
    logic [shuffle_pkg::TotalDataWidth-1:0] d;
    logic [shuffle_pkg::TotalStrbWidth-1:0] st;
    logic [shuffle_pkg::TotalDataWidth-1:0] want;
    logic [shuffle_pkg::TotalStrbWidth-1:0] want_strb;
    for (int n = 0; n < count; n++) begin
      while (wr_req_q.size() == 0) begin
        @(posedge clk_i);
        #2;
      end
      req = wr_req_q.pop_front();
      for (int b = 0; b < req / 4; b++) begin
        d                = random_beat();
        st               = $random(seed);
        r                = $random(seed);
        cl_w_data_i.flat = d;
        cl_w_strb_i      = st;
        cl_w_last_i      = (b == req / 4 - 1);
        cl_w_valid_i     = r[3:0];
        do begin
          @(negedge clk_i);
          taken = ((cl_w_valid_i & cl_w_ready_o) == '1);
          if (!taken) begin
            @(posedge clk_i);
            #2;
            r            = $random(seed);
            cl_w_valid_i = cl_w_valid_i | r[3:0];
          end
        end while (!taken);
        shuffle_model(d, st, req % 4, 1'b0, want, want_strb);
        wr_exp_q.push_back(want);
        wr_strb_q.push_back(want_strb);
        wr_last_q.push_back(cl_w_last_i);
        wr_sent++;
        @(posedge clk_i);
        #2;
        cl_w_valid_i = '0;
      end
    end
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Readies of memory and clusters, forced open on AR during the full-tracker phase
  initial begin : ready_driver
    int r;
    forever begin
      @(posedge clk_i);
      #2;
      r              = $random(seed);
      mem_ar_ready_i = directed | (r[1:0] != 2'b00);
      mem_aw_ready_i = r[3:2] != 2'b00;
      mem_w_ready_i  = r[5:4] != 2'b00;
      cl_r_ready_i   = r[11:8] | r[15:12];
    end
  end

  // Request valids reach memory unchanged, whatever the tracker state
  initial begin : request_monitor
    forever begin
      @(negedge clk_i);
      assert (mem_ar_valid_o === ar_valid_i)
        else stop_with_error($sformatf("FAILED mem_ar_valid_o: got %h, expected %h",
                                       mem_ar_valid_o, ar_valid_i));
      assert (mem_aw_valid_o === aw_valid_i)
        else stop_with_error($sformatf("FAILED mem_aw_valid_o: got %h, expected %h",
                                       mem_aw_valid_o, aw_valid_i));
    end
  end

  initial begin : read_monitor
    shuffle_pkg::beat_u want;
    forever begin
      @(negedge clk_i);
      for (int c = 0; c < shuffle_pkg::NrClusters; c++) begin
        if (rst_ni && cl_r_valid_o[c] && cl_r_ready_i[c]) begin
          assert (rd_exp_q.size() > 0)
            else stop_with_error("A cluster accepted a read beat that was never sent");
          want.flat = rd_exp_q[0];
          assert (cl_r_data_o.cluster[c] === want.cluster[c])
            else stop_with_error($sformatf("FAILED cl_r_data_o cluster %0d: got %h, expected %h",
                                           c, cl_r_data_o.cluster[c], want.cluster[c]));
          assert (cl_r_last_o === rd_last_q[0])
            else stop_with_error($sformatf("FAILED cl_r_last_o: got %h, expected %h",
                                           cl_r_last_o, rd_last_q[0]));
          rd_taken[c] = 1'b1;
        end
      end
      if (&rd_taken) begin
        void'(rd_exp_q.pop_front());
        void'(rd_last_q.pop_front());
        rd_taken = '0;
        rd_checked++;
      end
    end
  end

  initial begin : write_monitor
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_w_valid_o && mem_w_ready_i) begin
        assert (wr_exp_q.size() > 0)
          else stop_with_error("Memory received a write beat that was never sent");
        assert (mem_w_data_o.flat === wr_exp_q[0])
          else stop_with_error($sformatf("FAILED mem_w_data_o: got %h, expected %h",
                                         mem_w_data_o.flat, wr_exp_q[0]));
        assert (mem_w_strb_o === wr_strb_q[0])
          else stop_with_error($sformatf("FAILED mem_w_strb_o: got %h, expected %h",
                                         mem_w_strb_o, wr_strb_q[0]));
        assert (mem_w_last_o === wr_last_q[0])
          else stop_with_error($sformatf("FAILED mem_w_last_o: got %h, expected %h",
                                         mem_w_last_o, wr_last_q[0]));
        void'(wr_exp_q.pop_front());
        void'(wr_strb_q.pop_front());
        void'(wr_last_q.pop_front());
        wr_checked++;
      end
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    stop_with_error($sformatf("Timeout, traffic still running after %0d cycles", WatchdogCycles));
  end

  initial begin : bound_check_watch
    wait (DUT.u_shuffle_asserts.fail_cnt != 0);
    stop_with_error("A bound handshake assertion on shuffle_top failed");
  end

  initial begin : main
    {ar_valid_i, aw_valid_i, mem_r_valid_i, mem_r_last_i, cl_w_last_i} = '0;
    {ar_vew_i, aw_vew_i, cl_w_valid_i, cl_w_strb_i} = '0;
    {mem_ar_ready_i, mem_aw_ready_i, mem_w_ready_i, cl_r_ready_i} = '0;
    mem_r_data_i.flat = '0;
    cl_w_data_i.flat  = '0;
    rd_taken          = '0;
    directed          = 1'b1;
    rd_hold           = 1'b1;
    rst_ni            = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (mem_r_ready_o && cl_r_valid_o == '0 && !mem_w_valid_o && !mem_ar_valid_o
            && !mem_aw_valid_o && ar_ready_o == mem_ar_ready_i
            && aw_ready_o == mem_aw_ready_i)
      else stop_with_error("Ready and valid outputs are wrong right after reset");
    @(posedge clk_i);
    #2;
    fork
      begin
        // Fill the read tracker while memory returns nothing
        request_stream(1'b1, 8);
        @(negedge clk_i);
        assert (ar_ready_o == 1'b0)
          else stop_with_error("ar_ready_o stays high with eight read requests outstanding");
        directed = 1'b0;
        rd_hold  = 1'b0;
        @(posedge clk_i);
        #2;
        request_stream(1'b1, NumReqs - 8);
      end
      read_data_stream(NumReqs);
      request_stream(1'b0, NumReqs);
      write_data_stream(NumReqs);
    join
    wait (rd_exp_q.size() == 0 && wr_exp_q.size() == 0);
    @(negedge clk_i);
    if (rd_checked == rd_sent && wr_checked == wr_sent && rd_taken == '0
        && cl_r_valid_o == '0 && !mem_w_valid_o) begin
      $display("test passed");
      $finish;
    end else begin
      stop_with_error($sformatf("Outputs still busy after %0d read and %0d write beats",
                                rd_checked, wr_checked));
    end
  end

endmodule
